// File: Bender.yml
package:
  name: av_core

sources:
  - hw/av_pkg.sv
  - hw/av_regs.sv
  - hw/video_timing.sv
  - hw/i2s_tx.sv
  - hw/av_core_top.sv
  - target: test
    files:
      - sim/tb_av_core_top.sv

// File: hw/av_core_top.sv
// audio-video core top level
// register block beside the raster generator and the i2s transmitter,
// all on the audio master clock
module av_core_top #(
    parameter int H_TOTAL  = 400,
    parameter int H_ACTIVE = 320,
    parameter int H_BPORCH = 10,
    parameter int V_TOTAL  = 512,
    parameter int V_ACTIVE = 240,
    parameter int V_BPORCH = 10
) (
    input  logic                             audgen_mclk,
    input  logic                             reset_n,
    // AXI4-Lite slave
    input  logic                             awvalid,
    output logic                             awready,
    input  logic [av_pkg::AXIL_ADDR_W-1:0]   awaddr,
    input  logic                             wvalid,
    output logic                             wready,
    input  logic [av_pkg::AXIL_DATA_W-1:0]   wdata,
    input  logic [av_pkg::AXIL_DATA_W/8-1:0] wstrb,
    output logic                             bvalid,
    input  logic                             bready,
    input  logic                             arvalid,
    output logic                             arready,
    input  logic [av_pkg::AXIL_ADDR_W-1:0]   araddr,
    output logic                             rvalid,
    input  logic                             rready,
    output logic [av_pkg::AXIL_DATA_W-1:0]   rdata,
    // pixel source
    input  logic [av_pkg::PIX_W-1:0]         pixel_rgb,
    // video to scaler
    output logic [av_pkg::RGB_W-1:0]         video_rgb,
    output logic                             video_de,
    output logic                             video_vs,
    output logic                             video_hs,
    // i2s out
    output logic                             audio_sclk,
    output logic                             audio_lrck,
    output logic                             audio_dac
);

    // register block to the video and audio paths
    logic                        video_en;
    logic                        audio_en;
    logic [av_pkg::SAMPLE_W-1:0] sample_left;
    logic [av_pkg::SAMPLE_W-1:0] sample_right;
    logic [av_pkg::FRAME_W-1:0]  frame_count;

    av_regs i_av_regs (
        .audgen_mclk (audgen_mclk),   .reset_n      (reset_n),
        .awvalid     (awvalid),       .awready      (awready),
        .awaddr      (awaddr),        .wvalid       (wvalid),
        .wready      (wready),        .wdata        (wdata),
        .wstrb       (wstrb),         .bvalid       (bvalid),
        .bready      (bready),        .arvalid      (arvalid),
        .arready     (arready),       .araddr       (araddr),
        .rvalid      (rvalid),        .rready       (rready),
        .rdata       (rdata),         .frame_count  (frame_count),
        .video_en    (video_en),      .audio_en     (audio_en),
        .sample_left (sample_left),   .sample_right (sample_right)
    );

    video_timing #(
        .H_TOTAL  (H_TOTAL),  .H_ACTIVE (H_ACTIVE), .H_BPORCH (H_BPORCH),
        .V_TOTAL  (V_TOTAL),  .V_ACTIVE (V_ACTIVE), .V_BPORCH (V_BPORCH)
    ) i_video_timing (
        .audgen_mclk (audgen_mclk),   .reset_n     (reset_n),
        .video_en    (video_en),      .pixel_rgb   (pixel_rgb),
        .video_rgb   (video_rgb),     .video_de    (video_de),
        .video_vs    (video_vs),      .video_hs    (video_hs),
        .frame_count (frame_count)
    );

    i2s_tx i_i2s_tx (
        .audgen_mclk  (audgen_mclk),  .reset_n     (reset_n),
        .audio_en     (audio_en),     .sample_left (sample_left),
        .sample_right (sample_right), .audio_sclk  (audio_sclk),
        .audio_lrck   (audio_lrck),   .audio_dac   (audio_dac)
    );

endmodule

// File: hw/av_pkg.sv
// audio-video output core, shared definitions
// bus widths, register map, control bits, raster and i2s framing constants
package av_pkg;

    //////////////////////////////////////////////////////////////
    // register bus
    //////////////////////////////////////////////////////////////

    localparam int AXIL_ADDR_W = 4;
    localparam int AXIL_DATA_W = 32;

    // byte offsets of the four registers
    localparam logic [AXIL_ADDR_W-1:0] REG_CTRL      = 4'h0;
    localparam logic [AXIL_ADDR_W-1:0] REG_AUD_LEFT  = 4'h4;
    localparam logic [AXIL_ADDR_W-1:0] REG_AUD_RIGHT = 4'h8;
    localparam logic [AXIL_ADDR_W-1:0] REG_STATUS    = 4'hC;

    // enables in the control register
    localparam int CTRL_VIDEO_EN_BIT = 0;
    localparam int CTRL_AUDIO_EN_BIT = 1;

    //////////////////////////////////////////////////////////////
    // video
    //////////////////////////////////////////////////////////////

    // 4 bits per component in, 8 bits per channel out
    localparam int PIX_W   = 12;
    localparam int RGB_W   = 24;
    localparam int CNT_W   = 10;
    localparam int FRAME_W = 16;
    // hs starts a few clocks into the line, never on the vs cycle
    localparam int HS_OFFSET = 3;

    //////////////////////////////////////////////////////////////
    // audio
    //////////////////////////////////////////////////////////////

    localparam int SAMPLE_W      = 16;
    localparam int I2S_SLOT_BITS = 32;
    // sclk = mclk / 4
    localparam int SCLK_DIV_W    = 2;

endpackage

// File: hw/av_regs.sv
// AXI4-Lite register block for the audio-video core
// holds the video and audio enables and both audio samples,
// reports the frame counter in the status register
module av_regs (
    input  logic                            audgen_mclk,
    input  logic                            reset_n,
    // write address and data
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [av_pkg::AXIL_ADDR_W-1:0]  awaddr,
    input  logic                            wvalid,
    output logic                            wready,
    input  logic [av_pkg::AXIL_DATA_W-1:0]  wdata,
    input  logic [av_pkg::AXIL_DATA_W/8-1:0] wstrb,
    // write response
    output logic                            bvalid,
    input  logic                            bready,
    // read address and data
    input  logic                            arvalid,
    output logic                            arready,
    input  logic [av_pkg::AXIL_ADDR_W-1:0]  araddr,
    output logic                            rvalid,
    input  logic                            rready,
    output logic [av_pkg::AXIL_DATA_W-1:0]  rdata,
    // core side
    input  logic [av_pkg::FRAME_W-1:0]      frame_count,
    output logic                            video_en,
    output logic                            audio_en,
    output logic [av_pkg::SAMPLE_W-1:0]     sample_left,
    output logic [av_pkg::SAMPLE_W-1:0]     sample_right
);

    localparam int DATA_W = av_pkg::AXIL_DATA_W;
    localparam int STRB_W = av_pkg::AXIL_DATA_W / 8;

    logic [DATA_W-1:0] ctrl_q;
    logic [DATA_W-1:0] left_q;
    logic [DATA_W-1:0] right_q;

    // one pulse per accepted write, shared by awready and wready
    logic              wr_ack_q;
    logic              wr_accept;
    logic              rd_accept;
    logic [DATA_W-1:0] rd_mux;

    // byte lanes with strobe low keep the old value
    function automatic logic [DATA_W-1:0] merge_bytes(
        input logic [DATA_W-1:0] old_val,
        input logic [DATA_W-1:0] new_val,
        input logic [STRB_W-1:0] strb
    );
        logic [DATA_W-1:0] merged;
        merged = old_val;
        for (int i = 0; i < STRB_W; i++) begin
            if (strb[i]) begin
                merged[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return merged;
    endfunction

    ////////////////////////////////////////////////////////////
    // write channel
    ////////////////////////////////////////////////////////////

    // address and data must arrive together
    // a pending response or the ack cycle itself blocks a new accept
    assign wr_accept = awvalid && wvalid && !bvalid && !wr_ack_q;

    assign awready = wr_ack_q;
    assign wready  = wr_ack_q;

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ack_q <= 1'b0;
            bvalid   <= 1'b0;
            ctrl_q   <= '0;
            left_q   <= '0;
            right_q  <= '0;
        end else begin
            wr_ack_q <= wr_accept;
            // response follows the ack by one cycle
            if (wr_ack_q) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            // register update lands together with the ack
            if (wr_accept) begin
                case (awaddr)
                    av_pkg::REG_CTRL:      ctrl_q  <= merge_bytes(ctrl_q, wdata, wstrb);
                    av_pkg::REG_AUD_LEFT:  left_q  <= merge_bytes(left_q, wdata, wstrb);
                    av_pkg::REG_AUD_RIGHT: right_q <= merge_bytes(right_q, wdata, wstrb);
                    // status is read only, unmapped offsets dropped
                    default: ;
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // read channel
    ////////////////////////////////////////////////////////////

    assign rd_accept = arvalid && !rvalid && !arready;

    always_comb begin
        case (araddr)
            av_pkg::REG_CTRL:      rd_mux = ctrl_q;
            av_pkg::REG_AUD_LEFT:  rd_mux = left_q;
            av_pkg::REG_AUD_RIGHT: rd_mux = right_q;
            av_pkg::REG_STATUS:    rd_mux = DATA_W'(frame_count);
            default:               rd_mux = '0;
        endcase
    end

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
        end else begin
            arready <= rd_accept;
            // araddr still held by the master in the arready cycle
            if (arready) begin
                rvalid <= 1'b1;
                rdata  <= rd_mux;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // core side views of the registers
    assign video_en     = ctrl_q[av_pkg::CTRL_VIDEO_EN_BIT];
    assign audio_en     = ctrl_q[av_pkg::CTRL_AUDIO_EN_BIT];
    assign sample_left  = left_q[av_pkg::SAMPLE_W-1:0];
    assign sample_right = right_q[av_pkg::SAMPLE_W-1:0];

    // responses hold until the master takes them
    a_bvalid_hold: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        bvalid && !bready |=> bvalid);
    a_rdata_hold: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

// File: hw/i2s_tx.sv
// i2s transmitter
// sclk = mclk / 4, 32 bit clocks per channel slot,
// 16-bit sample msb first then 16 zero bits, silence when disabled
module i2s_tx (
    input  logic                        audgen_mclk,
    input  logic                        reset_n,
    input  logic                        audio_en,
    input  logic [av_pkg::SAMPLE_W-1:0] sample_left,
    input  logic [av_pkg::SAMPLE_W-1:0] sample_right,
    output logic                        audio_sclk,
    output logic                        audio_lrck,
    output logic                        audio_dac
);

    localparam int BIT_CNT_W = $clog2(av_pkg::I2S_SLOT_BITS);
    localparam logic [BIT_CNT_W-1:0] SLOT_LAST = BIT_CNT_W'(av_pkg::I2S_SLOT_BITS - 1);

    logic [av_pkg::SCLK_DIV_W-1:0] sclk_div;
    logic                          sclk_fall;
    logic [BIT_CNT_W-1:0]          bit_cnt;
    logic [av_pkg::SAMPLE_W-1:0]   shift_q;
    logic [av_pkg::SAMPLE_W-1:0]   next_sample;

    ////////////////////////////////////////////////////////////
    // bit clock
    ////////////////////////////////////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            sclk_div <= '0;
        end else begin
            sclk_div <= sclk_div + 1'b1;
        end
    end

    // msb of the divider is the bit clock
    assign audio_sclk = sclk_div[av_pkg::SCLK_DIV_W-1];
    // divider wraps on this edge, so sclk drops with it
    assign sclk_fall  = (sclk_div == '1);

    ////////////////////////////////////////////////////////////
    // slot framing and serializer
    ////////////////////////////////////////////////////////////

    // lrck high now means the left slot comes next
    assign next_sample = !audio_en   ? '0 :
                         audio_lrck  ? sample_left : sample_right;

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            bit_cnt    <= '0;
            audio_lrck <= 1'b0;
            audio_dac  <= 1'b0;
            shift_q    <= '0;
        end else if (sclk_fall) begin
            if (bit_cnt == SLOT_LAST) begin
                // slot boundary, swap channel and latch its sample
                bit_cnt    <= '0;
                audio_lrck <= ~audio_lrck;
                audio_dac  <= next_sample[av_pkg::SAMPLE_W-1];
                shift_q    <= next_sample << 1;
            end else begin
                bit_cnt   <= bit_cnt + 1'b1;
                // zeros shift in behind the sample, padding the slot
                audio_dac <= shift_q[av_pkg::SAMPLE_W-1];
                shift_q   <= shift_q << 1;
            end
        end
    end

    // channel select moves only with the bit clock falling
    a_lrck_on_fall: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        $changed(audio_lrck) |-> $fell(audio_sclk));

endmodule

// File: hw/video_timing.sv
// raster timing generator for the video output
// column and line counters, vs/hs/de pulses, pixel registering,
// 4-bit colour packing into 8-bit channels, frame counter
module video_timing #(
    parameter int H_TOTAL  = 400,
    parameter int H_ACTIVE = 320,
    parameter int H_BPORCH = 10,
    parameter int V_TOTAL  = 512,
    parameter int V_ACTIVE = 240,
    parameter int V_BPORCH = 10
) (
    input  logic                         audgen_mclk,
    input  logic                         reset_n,
    input  logic                         video_en,
    input  logic [av_pkg::PIX_W-1:0]     pixel_rgb,
    output logic [av_pkg::RGB_W-1:0]     video_rgb,
    output logic                         video_de,
    output logic                         video_vs,
    output logic                         video_hs,
    output logic [av_pkg::FRAME_W-1:0]   frame_count
);

    localparam int CW = av_pkg::CNT_W;

    // counter limits at counter width
    localparam logic [CW-1:0] H_LAST  = CW'(H_TOTAL - 1);
    localparam logic [CW-1:0] V_LAST  = CW'(V_TOTAL - 1);
    localparam logic [CW-1:0] H_START = CW'(H_BPORCH);
    localparam logic [CW-1:0] H_END   = CW'(H_BPORCH + H_ACTIVE);
    localparam logic [CW-1:0] V_START = CW'(V_BPORCH);
    localparam logic [CW-1:0] V_END   = CW'(V_BPORCH + V_ACTIVE);
    localparam logic [CW-1:0] HS_COL  = CW'(av_pkg::HS_OFFSET);

    logic [CW-1:0]            x_count;
    logic [CW-1:0]            y_count;
    logic                     in_active;
    logic [av_pkg::PIX_W-1:0] pix_q;
    logic [av_pkg::RGB_W-1:0] pix_packed;

    ////////////////////////////////////////////////////////////
    // raster counters
    ////////////////////////////////////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            x_count <= '0;
            y_count <= '0;
        end else if (x_count == H_LAST) begin
            x_count <= '0;
            // wrap the line counter at frame end
            y_count <= (y_count == V_LAST) ? '0 : y_count + 1'b1;
        end else begin
            x_count <= x_count + 1'b1;
        end
    end

    assign in_active = (x_count >= H_START) && (x_count < H_END) &&
                       (y_count >= V_START) && (y_count < V_END);

    ////////////////////////////////////////////////////////////
    // pixel path
    ////////////////////////////////////////////////////////////

    // first stage, raw 12-bit pixel
    always_ff @(posedge audgen_mclk) begin
        pix_q <= pixel_rgb;
    end

    // r, g, b into the high nibble, low nibble black
    assign pix_packed = {pix_q[11:8], 4'h0, pix_q[7:4], 4'h0, pix_q[3:0], 4'h0};

    ////////////////////////////////////////////////////////////
    // sync, de and colour out
    ////////////////////////////////////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            video_vs    <= 1'b0;
            video_hs    <= 1'b0;
            video_de    <= 1'b0;
            video_rgb   <= '0;
            frame_count <= '0;
        end else begin
            // new frame at the raster origin
            video_vs <= (x_count == '0) && (y_count == '0);
            if ((x_count == '0) && (y_count == '0)) begin
                frame_count <= frame_count + 1'b1;
            end
            // new line, a few clocks after vs
            video_hs <= (x_count == HS_COL);
            video_de <= in_active;
            // blanking and disabled video are black
            video_rgb <= (in_active && video_en) ? pix_packed : '0;
        end
    end

    // sync pulses sit in the porch, apart from each other
    a_sync_apart: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        !(video_vs && video_hs));
    a_de_no_sync: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        video_de |-> !(video_vs || video_hs));

endmodule

// File: sim/tb_av_core_top.sv
// testbench for the audio-video core
// register table over AXI4-Lite, raster and colour monitor, i2s slot monitor
module tb_av_core_top;

    localparam int H_TOTAL   = 40;
    localparam int H_ACTIVE  = 16;
    localparam int H_BPORCH  = 4;
    localparam int V_TOTAL   = 20;
    localparam int V_ACTIVE  = 8;
    localparam int V_BPORCH  = 2;
    localparam int BUS_LIMIT = 64;
    localparam int SLOT_MCLK = 4 * av_pkg::I2S_SLOT_BITS;

    logic                             audgen_mclk;
    logic                             reset_n;
    logic                             awvalid, wvalid, bready, arvalid, rready;
    logic                             awready, wready, bvalid, arready, rvalid;
    logic [av_pkg::AXIL_ADDR_W-1:0]   awaddr, araddr;
    logic [av_pkg::AXIL_DATA_W-1:0]   wdata, rdata;
    logic [av_pkg::AXIL_DATA_W/8-1:0] wstrb;
    logic [av_pkg::PIX_W-1:0]         pixel_rgb;
    logic [av_pkg::RGB_W-1:0]         video_rgb;
    logic                             video_de, video_vs, video_hs;
    logic                             audio_sclk, audio_lrck, audio_dac;

    typedef struct {
        bit          is_write;
        logic [3:0]  addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [31:0] exp_val;
    } reg_op_t;

    reg_op_t reg_table[$];

    // raster monitor state, times in mclk cycles
    int   cyc, vs_count, last_vs, last_hs, de_run, lines, frames_checked, rgb_checked;
    bit   vs_seen, hs_seen, hs_pending;
    // 0 black expected, 1 pixel expected, 2 enable in flight
    int   rgb_mode;
    logic [av_pkg::PIX_W-1:0] pix_d1, pix_d2;
    // audio register model and slot collector
    bit          aen_m, last_lrck, slot_open;
    logic [15:0] left_m, right_m;
    logic [31:0] slot_word, slot_exp;
    int          slot_bits, slots_done;

    av_core_top #(
        .H_TOTAL  (H_TOTAL),  .H_ACTIVE (H_ACTIVE), .H_BPORCH (H_BPORCH),
        .V_TOTAL  (V_TOTAL),  .V_ACTIVE (V_ACTIVE), .V_BPORCH (V_BPORCH)
    ) i_av_core_top (.*);

    always #20 audgen_mclk = ~audgen_mclk;

    // fresh random pixel every clock
    always @(posedge audgen_mclk) begin
        pixel_rgb <= av_pkg::PIX_W'($urandom);
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[FAIL] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic abort_run(input string msg);
        $display("ERROR at t=%0t: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // each 4-bit component goes to the top nibble of its 8-bit channel
    function automatic logic [23:0] expand_colour(input logic [11:0] pix);
        logic [23:0] rgb;
        rgb = '0;
        for (int c = 0; c < 3; c++) begin
            rgb[8*c+4 +: 4] = pix[4*c +: 4];
        end
        return rgb;
    endfunction

    function automatic void add_op(input bit wr, input logic [3:0] addr,
                                   input logic [31:0] data, input logic [3:0] strb,
                                   input logic [31:0] exp_val);
        reg_op_t op;
        op = '{wr, addr, data, strb, exp_val};
        reg_table.push_back(op);
    endfunction

    //////////////////////////////////////////////////////////////
    // bus tasks
    //////////////////////////////////////////////////////////////

    task automatic bus_write(input logic [3:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        int n;
        int delay;
        delay = $urandom_range(5, 0);
        @(posedge audgen_mclk);
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= strb;
        n = 0;
        @(negedge audgen_mclk);
        while (!awready) begin
            n++;
            assert (n <= BUS_LIMIT) else abort_run("no awready for a pending write");
            @(negedge audgen_mclk);
        end
        assert (wready) else report_mismatch("wready", wready, 1);
        // response one cycle after the accept
        @(negedge audgen_mclk);
        assert (bvalid) else report_mismatch("bvalid", bvalid, 1);
        // valids stay up, so a second accept would show here
        repeat (delay) begin
            @(negedge audgen_mclk);
            assert (bvalid) else report_mismatch("bvalid under back-pressure", bvalid, 1);
            assert (!awready) else abort_run("second awready while bvalid was pending");
        end
        @(posedge audgen_mclk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        bready  <= 1'b1;
        n = 0;
        @(negedge audgen_mclk);
        while (bvalid) begin
            n++;
            assert (n <= BUS_LIMIT) else abort_run("bvalid never dropped after bready");
            @(negedge audgen_mclk);
        end
        @(posedge audgen_mclk);
        bready <= 1'b0;
    endtask

    task automatic bus_read(input logic [3:0] addr, output logic [31:0] data);
        int n;
        int delay;
        delay = $urandom_range(5, 0);
        @(posedge audgen_mclk);
        arvalid <= 1'b1;
        araddr  <= addr;
        n = 0;
        @(negedge audgen_mclk);
        while (!arready) begin
            n++;
            assert (n <= BUS_LIMIT) else abort_run("no arready for a pending read");
            @(negedge audgen_mclk);
        end
        // new address after the accept must not reach rdata
        @(posedge audgen_mclk);
        araddr <= addr ^ 4'h4;
        @(negedge audgen_mclk);
        assert (rvalid) else report_mismatch("rvalid", rvalid, 1);
        data = rdata;
        repeat (delay) begin
            @(negedge audgen_mclk);
            assert (rvalid) else report_mismatch("rvalid under back-pressure", rvalid, 1);
            assert (rdata == data) else report_mismatch("rdata under back-pressure", rdata, data);
            assert (!arready) else abort_run("second arready while rvalid was pending");
        end
        @(posedge audgen_mclk);
        arvalid <= 1'b0;
        rready  <= 1'b1;
        n = 0;
        @(negedge audgen_mclk);
        while (rvalid) begin
            n++;
            assert (n <= BUS_LIMIT) else abort_run("rvalid never dropped after rready");
            @(negedge audgen_mclk);
        end
        @(posedge audgen_mclk);
        rready <= 1'b0;
    endtask

    // land a full write well inside a left i2s slot, then update the model
    task automatic write_mid_slot(input logic [3:0] addr, input logic [31:0] data);
        logic lr;
        int   n;
        @(negedge audgen_mclk);
        lr = audio_lrck;
        n  = 0;
        // wait for lrck to fall into the left slot
        while (!(lr && !audio_lrck)) begin
            n++;
            assert (n <= 2 * SLOT_MCLK + 8) else abort_run("audio_lrck stopped toggling");
            lr = audio_lrck;
            @(negedge audgen_mclk);
        end
        repeat (40) @(negedge audgen_mclk);
        bus_write(addr, data, 4'hF);
        case (addr)
            av_pkg::REG_CTRL:      aen_m   = data[av_pkg::CTRL_AUDIO_EN_BIT];
            av_pkg::REG_AUD_LEFT:  left_m  = data[15:0];
            av_pkg::REG_AUD_RIGHT: right_m = data[15:0];
            default: ;
        endcase
    endtask

    task automatic wait_slots(input int count);
        int target;
        int n;
        target = slots_done + count;
        n = 0;
        while (slots_done < target) begin
            @(negedge audgen_mclk);
            n++;
            assert (n <= (count + 1) * SLOT_MCLK) else abort_run("i2s slots stopped arriving");
        end
    endtask

    // read status right after a vs so no frame starts during the read
    task automatic check_status();
        logic [31:0] rd;
        int          n;
        n = 0;
        @(negedge audgen_mclk);
        while (!video_vs) begin
            n++;
            assert (n <= H_TOTAL * V_TOTAL + 4) else abort_run("no video_vs within a frame");
            @(negedge audgen_mclk);
        end
        bus_read(av_pkg::REG_STATUS, rd);
        assert (rd == 32'(vs_count % 65536))
            else report_mismatch("status frame_count", rd, 32'(vs_count % 65536));
    endtask

    //////////////////////////////////////////////////////////////
    // monitors
    //////////////////////////////////////////////////////////////

    always @(negedge audgen_mclk) begin
        if (reset_n) begin
            cyc++;
            // colour path, pixel from two clocks back
            if (!video_de || rgb_mode == 0) begin
                assert (video_rgb == '0) else report_mismatch("video_rgb", video_rgb, 0);
            end else if (rgb_mode == 1) begin
                assert (video_rgb == expand_colour(pix_d2))
                    else report_mismatch("video_rgb", video_rgb, expand_colour(pix_d2));
                rgb_checked++;
            end
            // active run length per line
            if (video_de) begin
                de_run++;
            end else if (de_run != 0) begin
                assert (de_run == H_ACTIVE) else report_mismatch("video_de run", de_run, H_ACTIVE);
                lines++;
                de_run = 0;
            end
            if (video_vs) begin
                vs_count++;
                if (vs_seen) begin
                    assert (cyc - last_vs == H_TOTAL * V_TOTAL)
                        else report_mismatch("video_vs period", cyc - last_vs, H_TOTAL * V_TOTAL);
                    assert (lines == V_ACTIVE) else report_mismatch("active lines", lines, V_ACTIVE);
                    frames_checked++;
                end
                lines      = 0;
                last_vs    = cyc;
                vs_seen    = 1'b1;
                hs_pending = 1'b1;
            end
            if (video_hs) begin
                if (hs_seen) begin
                    assert (cyc - last_hs == H_TOTAL)
                        else report_mismatch("video_hs period", cyc - last_hs, H_TOTAL);
                end
                if (hs_pending) begin
                    assert (cyc - last_vs == av_pkg::HS_OFFSET)
                        else report_mismatch("video_hs after vs", cyc - last_vs, av_pkg::HS_OFFSET);
                end
                hs_pending = 1'b0;
                hs_seen    = 1'b1;
                last_hs    = cyc;
            end
        end
        pix_d2 = pix_d1;
        pix_d1 = pixel_rgb;
    end

    // bits taken on the rising bit clock, a slot closes when lrck moves
    always @(posedge audio_sclk) begin
        if (audio_lrck != last_lrck) begin
            if (slot_open) begin
                assert (slot_bits == av_pkg::I2S_SLOT_BITS)
                    else report_mismatch("audio_lrck half length", slot_bits, 32);
                assert (slot_word == slot_exp)
                    else report_mismatch(audio_lrck ? "audio_dac left slot" : "audio_dac right slot",
                                         slot_word, slot_exp);
                slots_done++;
            end
            slot_open = 1'b1;
            slot_exp  = aen_m ? {(audio_lrck ? right_m : left_m), 16'h0} : '0;
            slot_bits = 0;
            slot_word = '0;
            last_lrck = audio_lrck;
        end
        slot_word = {slot_word[30:0], audio_dac};
        slot_bits++;
    end

    //////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////

    initial begin
        reg_op_t     op;
        logic [31:0] rd;
        void'($urandom(23385));
        audgen_mclk = 1'b0;
        reset_n     = 1'b0;
        awvalid     = 1'b0;
        wvalid      = 1'b0;
        bready      = 1'b0;
        arvalid     = 1'b0;
        rready      = 1'b0;
        awaddr      = '0;
        araddr      = '0;
        wdata       = '0;
        wstrb       = '0;
        pixel_rgb   = '0;
        rgb_mode    = 0;
        aen_m       = 1'b0;
        left_m      = '0;
        right_m     = '0;

        // reset values, full and strobed writes, read-only and unmapped offsets
        add_op(0, av_pkg::REG_CTRL,      '0,           4'h0, 32'h0);
        add_op(0, av_pkg::REG_AUD_LEFT,  '0,           4'h0, 32'h0);
        add_op(0, av_pkg::REG_AUD_RIGHT, '0,           4'h0, 32'h0);
        add_op(1, av_pkg::REG_AUD_LEFT,  32'hA5A51234, 4'hF, 32'h0);
        add_op(0, av_pkg::REG_AUD_LEFT,  '0,           4'h0, 32'hA5A51234);
        add_op(1, av_pkg::REG_AUD_LEFT,  32'hFFFF00CC, 4'h1, 32'h0);
        add_op(1, av_pkg::REG_AUD_LEFT,  32'h00005600, 4'h2, 32'h0);
        add_op(0, av_pkg::REG_AUD_LEFT,  '0,           4'h0, 32'hA5A556CC);
        add_op(1, av_pkg::REG_AUD_RIGHT, 32'h11223344, 4'hF, 32'h0);
        add_op(1, av_pkg::REG_AUD_RIGHT, 32'hDEADBEEF, 4'hC, 32'h0);
        add_op(0, av_pkg::REG_AUD_RIGHT, '0,           4'h0, 32'hDEAD3344);
        add_op(1, av_pkg::REG_CTRL,      32'hFFFFFFFC, 4'hF, 32'h0);
        add_op(1, av_pkg::REG_CTRL,      32'h00000000, 4'h0, 32'h0);
        add_op(0, av_pkg::REG_CTRL,      '0,           4'h0, 32'hFFFFFFFC);
        add_op(1, av_pkg::REG_CTRL,      32'h00000000, 4'hF, 32'h0);
        add_op(1, av_pkg::REG_STATUS,    32'hFFFFFFFF, 4'hF, 32'h0);
        add_op(1, 4'h2,                  32'hFFFFFFFF, 4'hF, 32'h0);
        add_op(0, 4'h2,                  '0,           4'h0, 32'h0);
        add_op(0, 4'hE,                  '0,           4'h0, 32'h0);
        add_op(0, av_pkg::REG_CTRL,      '0,           4'h0, 32'h0);
        add_op(0, av_pkg::REG_AUD_LEFT,  '0,           4'h0, 32'hA5A556CC);
        add_op(0, av_pkg::REG_AUD_RIGHT, '0,           4'h0, 32'hDEAD3344);

        repeat (7) @(posedge audgen_mclk);
        @(negedge audgen_mclk);
        assert ({awready, wready, bvalid, arready, rvalid} == '0)
            else abort_run("bus handshake outputs not low in reset");
        assert ({video_vs, video_hs, video_de, audio_sclk, audio_lrck, audio_dac} == '0)
            else abort_run("video or audio outputs not low in reset");
        assert (video_rgb == '0) else report_mismatch("video_rgb in reset", video_rgb, 0);
        @(posedge audgen_mclk);
        reset_n <= 1'b1;

        foreach (reg_table[i]) begin
            op = reg_table[i];
            if (op.is_write) begin
                bus_write(op.addr, op.data, op.strb);
            end else begin
                bus_read(op.addr, rd);
                assert (rd == op.exp_val)
                    else report_mismatch($sformatf("rdata at 0x%0h", op.addr), rd, op.exp_val);
            end
        end
        check_status();

        // silent slots first, samples loaded while audio is off
        wait_slots(2);
        write_mid_slot(av_pkg::REG_AUD_LEFT, 32'h0000C3A5);
        write_mid_slot(av_pkg::REG_AUD_RIGHT, 32'h00005A3C);
        wait_slots(2);
        // both enables on
        rgb_mode = 2;
        write_mid_slot(av_pkg::REG_CTRL, 32'h3);
        @(posedge audgen_mclk);
        rgb_mode = 1;
        wait_slots(8);
        // new sample mid-slot
        write_mid_slot(av_pkg::REG_AUD_LEFT, 32'h00008001);
        wait_slots(3);
        rgb_mode = 2;
        write_mid_slot(av_pkg::REG_CTRL, 32'h0);
        @(posedge audgen_mclk);
        rgb_mode = 0;
        wait_slots(3);
        check_status();

        assert (frames_checked >= 2 && rgb_checked > 0)
            else abort_run("video monitor saw too few frames or pixels");
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: src.f
hw/av_pkg.sv
hw/av_regs.sv
hw/video_timing.sv
hw/i2s_tx.sv
hw/av_core_top.sv
sim/tb_av_core_top.sv
